// File: alu_pkg.sv
// ALU coprocessor shared types, opcode values, register map and bus structs
package alu_pkg;

  typedef logic [31:0] alu_word_t;   // Data word
  typedef logic [4:0]  alu_op_t;     // Bus-visible operation code
  typedef logic [1:0]  alu_addr_t;   // Register index, byte address bits 3:2
  typedef logic [2:0]  alu_flags_t;  // {borrow, negative, zero}

  localparam alu_op_t OP_AND    = 5'd0;
  localparam alu_op_t OP_OR     = 5'd1;
  localparam alu_op_t OP_ADD    = 5'd2;
  localparam alu_op_t OP_XOR    = 5'd3;
  localparam alu_op_t OP_SUB    = 5'd4;
  localparam alu_op_t OP_NOT    = 5'd5;
  localparam alu_op_t OP_SLL    = 5'd6;
  localparam alu_op_t OP_SRL    = 5'd7;
  localparam alu_op_t OP_SRA    = 5'd8;
  localparam alu_op_t OP_SLT    = 5'd9;
  localparam alu_op_t OP_SLTU   = 5'd10;
  localparam alu_op_t OP_MUL    = 5'd11;
  localparam alu_op_t OP_MULH   = 5'd12;
  localparam alu_op_t OP_MULHSU = 5'd13;
  localparam alu_op_t OP_MULHU  = 5'd14;
  localparam alu_op_t OP_DIV    = 5'd15;  // Decoded, no divider behind it
  localparam alu_op_t OP_DIVU   = 5'd16;
  localparam alu_op_t OP_REM    = 5'd17;
  localparam alu_op_t OP_REMU   = 5'd18;
  localparam alu_op_t OP_SUBU   = 5'd19;  // Unsigned subtract with borrow

  localparam alu_addr_t REG_A      = 2'd0;  // Write only
  localparam alu_addr_t REG_B      = 2'd1;  // Write only
  localparam alu_addr_t REG_OP     = 2'd2;  // Write issues, read gives status
  localparam alu_addr_t REG_RESULT = 2'd3;  // Read pops one result

  typedef struct packed {
    alu_op_t   op;
    alu_word_t a;
    alu_word_t b;
  } alu_cmd_t;

  typedef struct packed {
    alu_word_t  result;
    alu_flags_t flags;
  } alu_res_t;

  localparam int CMD_W = $bits(alu_cmd_t);  // 69
  localparam int RES_W = $bits(alu_res_t);  // 35

  typedef enum logic [1:0] {
    FRONT_IDLE,
    FRONT_WAIT,
    FRONT_ACK
  } front_state_t;

endpackage

// File: alu.sv
// Combinational integer ALU core producing a result word and zero/negative/borrow flags
`timescale 1ns/1ps

module alu (
  input  alu_pkg::alu_cmd_t cmd,
  output alu_pkg::alu_res_t res
);

  alu_pkg::alu_word_t  result;
  logic                borrow;
  logic [4:0]          shamt;
  logic signed [63:0]  prod_ss;
  logic signed [63:0]  prod_su;
  logic [63:0]         prod_uu;

  assign shamt = cmd.b[4:0];  // Only the low five bits count

  // Operands are extended to 64 bits before the multiply
  assign prod_ss = $signed(cmd.a) * $signed(cmd.b);
  assign prod_su = $signed(cmd.a) * $signed({1'b0, cmd.b});  // b kept positive
  assign prod_uu = cmd.a * cmd.b;

  always_comb
  begin
    borrow = 1'b0;
    result = '0;
    case (cmd.op)
      alu_pkg::OP_AND:
        result = cmd.a & cmd.b;
      alu_pkg::OP_OR:
        result = cmd.a | cmd.b;
      alu_pkg::OP_ADD:
        result = cmd.a + cmd.b;  // Wraps on overflow
      alu_pkg::OP_XOR:
        result = cmd.a ^ cmd.b;
      alu_pkg::OP_SUB:
        result = cmd.a - cmd.b;
      alu_pkg::OP_NOT:
        result = ~cmd.a;
      alu_pkg::OP_SLL:
        result = cmd.a << shamt;
      alu_pkg::OP_SRL:
        result = cmd.a >> shamt;
      alu_pkg::OP_SRA:
        result = $signed(cmd.a) >>> shamt;  // Sign bit fills from the top
      alu_pkg::OP_SLT:
        result = {31'b0, $signed(cmd.a) < $signed(cmd.b)};
      alu_pkg::OP_SLTU:
        result = {31'b0, cmd.a < cmd.b};
      alu_pkg::OP_MUL:
        result = prod_ss[31:0];
      alu_pkg::OP_MULH:
        result = prod_ss[63:32];
      alu_pkg::OP_MULHSU:
        result = prod_su[63:32];
      alu_pkg::OP_MULHU:
        result = prod_uu[63:32];
      alu_pkg::OP_DIV,
      alu_pkg::OP_DIVU,
      alu_pkg::OP_REM,
      alu_pkg::OP_REMU:
        result = '0;  // No divider
      alu_pkg::OP_SUBU:
        {borrow, result} = {1'b0, cmd.a} - {1'b0, cmd.b};  // Top bit is the borrow
      default:
        result = '0;
    endcase
  end

  // Zero and negative follow the result for every opcode
  assign res.result = result;
  assign res.flags  = {borrow, result[31], result == '0};

endmodule

// File: alu_fifo.sv
// Synchronous FIFO with parameter width and depth, push/pop, full and empty
`timescale 1ns/1ps

module alu_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] data,
  input  logic             pop,
  output logic [WIDTH-1:0] q,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;   // Ignored when full
  assign do_pop  = pop && !empty;   // Ignored when empty
  assign q       = mem[rd_ptr];     // Oldest entry

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= data;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at DEPTH
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// File: alu_cmd_front.sv
// Wishbone classic slave that latches operands, issues ALU commands and returns results
`timescale 1ns/1ps

module alu_cmd_front (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cyc,
  input  logic                stb,
  input  logic                we,
  input  logic [31:0]         adr,
  input  alu_pkg::alu_word_t  dat_w,
  input  logic                cmd_full,
  input  logic                res_empty,
  input  alu_pkg::alu_res_t   res_q,
  output alu_pkg::alu_word_t  dat_r,
  output logic                ack,
  output logic                cmd_push,
  output alu_pkg::alu_cmd_t   cmd_data,
  output logic                res_pop
);

  alu_pkg::front_state_t state;
  alu_pkg::front_state_t state_nxt;
  alu_pkg::alu_addr_t    reg_idx;
  alu_pkg::alu_word_t    a_q;
  alu_pkg::alu_word_t    b_q;
  alu_pkg::alu_flags_t   last_flags;
  logic                  req;
  logic                  op_write;
  logic                  res_read;
  logic                  ready;
  logic                  accept;

  assign req      = cyc && stb;
  assign reg_idx  = adr[3:2];  // Word registers
  assign op_write = we && (reg_idx == alu_pkg::REG_OP);
  assign res_read = !we && (reg_idx == alu_pkg::REG_RESULT);

  // Only command issue and result pop can be held up
  assign ready  = op_write ? !cmd_full : (res_read ? !res_empty : 1'b1);
  assign accept = req && ready && (state != alu_pkg::FRONT_ACK);
  assign ack    = (state == alu_pkg::FRONT_ACK);  // One cycle per transfer

  always_comb
  begin
    state_nxt = state;
    case (state)
      alu_pkg::FRONT_IDLE:
        if (req)
          state_nxt = ready ? alu_pkg::FRONT_ACK : alu_pkg::FRONT_WAIT;
      alu_pkg::FRONT_WAIT:
        if (!req)
          state_nxt = alu_pkg::FRONT_IDLE;  // Master gave up
        else if (ready)
          state_nxt = alu_pkg::FRONT_ACK;
      alu_pkg::FRONT_ACK:
        state_nxt = alu_pkg::FRONT_IDLE;
      default:
        state_nxt = alu_pkg::FRONT_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= alu_pkg::FRONT_IDLE;
      cmd_push   <= 1'b0;
      res_pop    <= 1'b0;
      last_flags <= '0;
    end
    else
    begin
      state    <= state_nxt;
      cmd_push <= accept && op_write;  // High together with ack
      res_pop  <= accept && res_read;
      if (accept && res_read)
        last_flags <= res_q.flags;     // Kept for status reads
    end
  end

  // Operand, command and read data registers load as a transfer is accepted
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (we)
      begin
        case (reg_idx)
          alu_pkg::REG_A:  a_q <= dat_w;
          alu_pkg::REG_B:  b_q <= dat_w;
          alu_pkg::REG_OP: cmd_data <= '{op: dat_w[4:0], a: a_q, b: b_q};
          default: ;  // Result register is read only
        endcase
      end
      else
      begin
        case (reg_idx)
          alu_pkg::REG_OP:     dat_r <= {27'b0, res_empty, cmd_full, last_flags};
          alu_pkg::REG_RESULT: dat_r <= res_q.result;  // Head of result FIFO
          default:             dat_r <= '0;            // Operands read as zero
        endcase
      end
    end
  end

endmodule

// File: alu_exec.sv
// Execute stage moving commands from the command FIFO through the ALU into the result FIFO
`timescale 1ns/1ps

module alu_exec (
  input  logic              cmd_empty,
  input  alu_pkg::alu_cmd_t cmd_q,
  input  logic              res_full,
  output logic              cmd_pop,
  output logic              res_push,
  output alu_pkg::alu_res_t res_data
);

  logic fire;

  // One command per cycle when there is work and room for the answer
  assign fire = !cmd_empty && !res_full;

  // Pop and push in the same cycle so nothing is held here
  assign cmd_pop  = fire;
  assign res_push = fire;

  alu i_alu (
    .cmd (cmd_q),
    .res (res_data)
  );

endmodule

// File: alu_top.sv
// ALU coprocessor top level joining bus front end, command and result FIFOs and execute stage
`timescale 1ns/1ps

module alu_top #(
  parameter int CMD_DEPTH = 4,
  parameter int RES_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cyc,
  input  logic               stb,
  input  logic               we,
  input  logic [31:0]        adr,
  input  alu_pkg::alu_word_t dat_w,
  output alu_pkg::alu_word_t dat_r,
  output logic               ack
);

  alu_pkg::alu_cmd_t cmd_data;
  alu_pkg::alu_cmd_t cmd_q;
  alu_pkg::alu_res_t res_data;
  alu_pkg::alu_res_t res_q;
  logic              cmd_push;
  logic              cmd_pop;
  logic              cmd_full;
  logic              cmd_empty;
  logic              res_push;
  logic              res_pop;
  logic              res_full;
  logic              res_empty;

  alu_cmd_front i_front (
    .clk       (clk),
    .rst_n     (rst_n),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .cmd_full  (cmd_full),
    .res_empty (res_empty),
    .res_q     (res_q),
    .dat_r     (dat_r),
    .ack       (ack),
    .cmd_push  (cmd_push),
    .cmd_data  (cmd_data),
    .res_pop   (res_pop)
  );

  alu_fifo #(
    .WIDTH (alu_pkg::CMD_W),
    .DEPTH (CMD_DEPTH)
  ) cmd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (cmd_push),
    .data  (cmd_data),
    .pop   (cmd_pop),
    .q     (cmd_q),
    .full  (cmd_full),
    .empty (cmd_empty)
  );

  alu_exec i_exec (
    .cmd_empty (cmd_empty),
    .cmd_q     (cmd_q),
    .res_full  (res_full),
    .cmd_pop   (cmd_pop),
    .res_push  (res_push),
    .res_data  (res_data)
  );

  alu_fifo #(
    .WIDTH (alu_pkg::RES_W),
    .DEPTH (RES_DEPTH)
  ) res_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (res_push),
    .data  (res_data),
    .pop   (res_pop),
    .q     (res_q),
    .full  (res_full),
    .empty (res_empty)
  );

endmodule

// File: alu_tb_assertions.sv
// Wishbone acknowledge checks for the ALU coprocessor, bound into alu_top
`timescale 1ns/1ps

module alu_tb_assertions (
  input logic clk,
  input logic rst_n,
  input logic cyc,
  input logic stb,
  input logic ack
);

  int violations = 0;  // Read by the testbench at the end of the run

  ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> (cyc && stb))
  else
  begin
    violations++;
    $error("ack raised without cyc and stb");
  end

  ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack)
  else
  begin
    violations++;
    $error("ack held high for two cycles in a row");
  end

  ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
  else
  begin
    violations++;
    $error("ack high in the cycle after reset");
  end

endmodule

bind alu_top alu_tb_assertions i_wb_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .cyc   (cyc),
  .stb   (stb),
  .ack   (ack)
);

// File: alu_tb.sv
// Testbench for the ALU coprocessor, driving its Wishbone port from a table of operations
`timescale 1ns/1ps

module alu_tb;

  localparam int CMD_DEPTH = 4;
  localparam int RES_DEPTH = 4;
  localparam int BURST_N   = CMD_DEPTH + RES_DEPTH + 2;  // Two more than both FIFOs hold

  typedef struct {
    string               name;
    alu_pkg::alu_op_t    op;
    alu_pkg::alu_word_t  a;
    alu_pkg::alu_word_t  b;
    alu_pkg::alu_word_t  exp_word;
    alu_pkg::alu_flags_t exp_flags;
  } test_t;

  logic               clk;
  logic               rst_n;
  logic               cyc;
  logic               stb;
  logic               we;
  logic [31:0]        adr;
  alu_pkg::alu_word_t dat_w;
  alu_pkg::alu_word_t dat_r;
  logic               ack;

  test_t       tests[$];
  logic [31:0] lfsr_state;
  int          cycles;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;

  alu_top #(
    .CMD_DEPTH (CMD_DEPTH),
    .RES_DEPTH (RES_DEPTH)
  ) i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);  // Galois feedback
  endfunction

  function automatic alu_pkg::alu_word_t draw_bits(input int n);
    alu_pkg::alu_word_t w;
    w = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // Reference model built from sign- and zero-extended 64-bit operands
  function automatic alu_pkg::alu_res_t model_alu(input alu_pkg::alu_op_t op,
      input alu_pkg::alu_word_t a, input alu_pkg::alu_word_t b);
    logic [63:0]        sa;
    logic [63:0]        sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    alu_pkg::alu_word_t r;
    logic               brw;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (op)
      alu_pkg::OP_AND:    r = a & b;
      alu_pkg::OP_OR:     r = a | b;
      alu_pkg::OP_ADD:    r = a + b;
      alu_pkg::OP_XOR:    r = a ^ b;
      alu_pkg::OP_SUB:    r = a - b;
      alu_pkg::OP_NOT:    r = ~a;
      alu_pkg::OP_SLL:    r = a << b[4:0];
      alu_pkg::OP_SRL:    r = a >> b[4:0];
      alu_pkg::OP_SRA:    r = 32'(sa >> b[4:0]);  // Upper copies of the sign shift in
      alu_pkg::OP_SLT:    r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      alu_pkg::OP_SLTU:   r = {31'b0, a < b};
      alu_pkg::OP_MUL:    r = 32'(ua * ub);
      alu_pkg::OP_MULH:   r = 32'((sa * sb) >> 32);
      alu_pkg::OP_MULHSU: r = 32'((sa * ub) >> 32);
      alu_pkg::OP_MULHU:  r = 32'((ua * ub) >> 32);
      alu_pkg::OP_SUBU:   r = a - b;
      default:            r = '0;  // Divide, remainder and unused codes
    endcase
    brw = (op == alu_pkg::OP_SUBU) && (a < b);
    return '{result: r, flags: {brw, r[31], r == 32'd0}};
  endfunction

  function automatic void add_test(input string name, input alu_pkg::alu_op_t op,
      input alu_pkg::alu_word_t a, input alu_pkg::alu_word_t b,
      input alu_pkg::alu_word_t exp_word, input alu_pkg::alu_flags_t exp_flags);
    test_t t;
    t.name      = name;
    t.op        = op;
    t.a         = a;
    t.b         = b;
    t.exp_word  = exp_word;
    t.exp_flags = exp_flags;
    tests.push_back(t);
  endfunction

  // Flags column is {borrow, negative, zero}
  function automatic void load_table();
    alu_pkg::alu_word_t a;
    alu_pkg::alu_word_t b;
    alu_pkg::alu_op_t   op;
    alu_pkg::alu_res_t  exp;
    add_test("and_mask", alu_pkg::OP_AND, 32'hF0F01234, 32'h0FF0FF00, 32'h00F01200, 3'b000);
    add_test("or_neg", alu_pkg::OP_OR, 32'h80000000, 32'h00000001, 32'h80000001, 3'b010);
    add_test("xor_zero", alu_pkg::OP_XOR, 32'h12345678, 32'h12345678, 32'h00000000, 3'b001);
    add_test("not", alu_pkg::OP_NOT, 32'h0000FFFF, 32'h00000000, 32'hFFFF0000, 3'b010);
    add_test("add_wrap", alu_pkg::OP_ADD, 32'hFFFFFFFF, 32'h00000002, 32'h00000001, 3'b000);
    add_test("add_zero", alu_pkg::OP_ADD, 32'h80000000, 32'h80000000, 32'h00000000, 3'b001);
    add_test("sub_neg", alu_pkg::OP_SUB, 32'h00000005, 32'h00000007, 32'hFFFFFFFE, 3'b010);
    add_test("sll_mask", alu_pkg::OP_SLL, 32'h00000001, 32'h00000024, 32'h00000010, 3'b000);
    add_test("srl_mask", alu_pkg::OP_SRL, 32'h80000000, 32'h00000021, 32'h40000000, 3'b000);
    add_test("sra_sign", alu_pkg::OP_SRA, 32'h80000000, 32'h00000004, 32'hF8000000, 3'b010);
    add_test("slt_neg", alu_pkg::OP_SLT, 32'hFFFFFFFF, 32'h00000001, 32'h00000001, 3'b000);
    add_test("sltu_neg", alu_pkg::OP_SLTU, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 3'b001);
    add_test("mul_low", alu_pkg::OP_MUL, 32'hFFFFFFFF, 32'h00000002, 32'hFFFFFFFE, 3'b010);
    add_test("mulh_small", alu_pkg::OP_MULH, 32'hFFFFFFFF, 32'h00000002, 32'hFFFFFFFF, 3'b010);
    add_test("mulhsu_small", alu_pkg::OP_MULHSU, 32'hFFFFFFFF, 32'h2, 32'hFFFFFFFF, 3'b010);
    add_test("mulhu_small", alu_pkg::OP_MULHU, 32'hFFFFFFFF, 32'h00000002, 32'h1, 3'b000);
    add_test("mulh_big", alu_pkg::OP_MULH, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h00000000, 3'b001);
    add_test("mulhsu_big", alu_pkg::OP_MULHSU, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF, 3'b010);
    add_test("mulhu_big", alu_pkg::OP_MULHU, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE, 3'b010);
    add_test("subu_borrow", alu_pkg::OP_SUBU, 32'h00000003, 32'h00000005, 32'hFFFFFFFE, 3'b110);
    add_test("subu_equal", alu_pkg::OP_SUBU, 32'h00000009, 32'h00000009, 32'h00000000, 3'b001);
    add_test("subu_plain", alu_pkg::OP_SUBU, 32'h0000000A, 32'h00000003, 32'h00000007, 3'b000);
    add_test("div_zero", alu_pkg::OP_DIV, 32'h00000064, 32'h00000005, 32'h00000000, 3'b001);
    add_test("rem_zero", alu_pkg::OP_REM, 32'h00000064, 32'h00000007, 32'h00000000, 3'b001);
    add_test("op_31", alu_pkg::alu_op_t'(31), 32'h00000011, 32'h00000022, 32'h0, 3'b001);
    for (int i = 0; i < 8; i++)
    begin
      op  = alu_pkg::alu_op_t'(draw_bits(5) % 20);  // Any defined code
      a   = draw_bits(32);
      b   = draw_bits(32);
      exp = model_alu(op, a, b);
      add_test($sformatf("random_%0d", i), op, a, b, exp.result, exp.flags);
    end
  endfunction

  task automatic wb_write(input alu_pkg::alu_addr_t idx, input alu_pkg::alu_word_t data);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= {28'b0, idx, 2'b00};
    dat_w <= data;
    @(posedge clk);
    while (ack !== 1'b1)
      @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  // Gives up after max_wait cycles without ack
  task automatic try_write(input alu_pkg::alu_addr_t idx, input alu_pkg::alu_word_t data,
      input int max_wait, output bit acked);
    int n;
    acked = 1'b0;
    n     = 0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= {28'b0, idx, 2'b00};
    dat_w <= data;
    while (!acked && n < max_wait)
    begin
      @(posedge clk);
      n++;
      acked = (ack === 1'b1);
    end
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input alu_pkg::alu_addr_t idx, output alu_pkg::alu_word_t data);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= {28'b0, idx, 2'b00};
    @(posedge clk);
    while (ack !== 1'b1)
      @(posedge clk);
    data = dat_r;  // Stable while ack is high
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic check_word(input string name, input alu_pkg::alu_word_t exp,
      input alu_pkg::alu_word_t act);
    if (act !== exp)
    begin
      $display("ERROR %s: result expected %h, actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flags(input string name, input alu_pkg::alu_flags_t exp,
      input alu_pkg::alu_flags_t act);
    if (act !== exp)
    begin
      $display("ERROR %s: flags expected %b, actual %b", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0)
    begin
      tests_passed++;
      $display("pass  %s", name);
    end
    else
    begin
      tests_failed++;
      $display("fail  %s", name);
    end
    test_errors = 0;
  endtask

  task automatic run_test(input test_t t);
    alu_pkg::alu_word_t word;
    alu_pkg::alu_word_t status;
    wb_write(alu_pkg::REG_A, t.a);
    wb_write(alu_pkg::REG_B, t.b);
    wb_write(alu_pkg::REG_OP, 32'(t.op));
    wb_read(alu_pkg::REG_RESULT, word);
    check_word(t.name, t.exp_word, word);
    wb_read(alu_pkg::REG_OP, status);
    check_flags(t.name, t.exp_flags, status[2:0]);  // Flags of the result just popped
    if (status[4] !== 1'b1)  // Only result already read
    begin
      $display("ERROR %s: status empty bit expected 1, actual %b", t.name, status[4]);
      test_errors++;
    end
    finish_test(t.name);
  endtask

  task automatic read_burst_result(inout int idx);
    alu_pkg::alu_word_t word;
    wb_read(alu_pkg::REG_RESULT, word);
    check_word({"burst_", tests[idx].name}, tests[idx].exp_word, word);
    idx++;
  endtask

  // Fill both FIFOs, then every further opcode write must wait for a read
  task automatic run_burst();
    alu_pkg::alu_word_t status;
    bit                 acked;
    int                 next_read;
    next_read = 0;
    for (int k = 0; k < BURST_N; k++)
    begin
      wb_write(alu_pkg::REG_A, tests[k].a);
      wb_write(alu_pkg::REG_B, tests[k].b);
      if (k < CMD_DEPTH + RES_DEPTH)
        wb_write(alu_pkg::REG_OP, 32'(tests[k].op));
      else
      begin
        wb_read(alu_pkg::REG_OP, status);
        if (!status[3])
        begin
          $display("burst: command FIFO not reported full before command %0d", k);
          test_errors++;
        end
        if (status[4] !== 1'b0)
        begin
          $display("burst: result FIFO reported empty while it holds results");
          test_errors++;
        end
        try_write(alu_pkg::REG_OP, 32'(tests[k].op), 12, acked);
        if (acked)
        begin
          $display("burst: command %0d was accepted while the command FIFO was full", k);
          test_errors++;
        end
        else
        begin
          read_burst_result(next_read);
          wb_write(alu_pkg::REG_OP, 32'(tests[k].op));  // Room again after one pop
        end
      end
    end
    while (next_read < BURST_N)
      read_burst_result(next_read);
    finish_test("burst");
  endtask

  initial
  begin : watchdog
    int limit;
    wait (rst_n === 1'b1);
    limit  = (tests.size() + BURST_N) * 20 + 200;
    cycles = 0;
    while (cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: tests still running after %0d cycles", limit);
    $display("Errors found");
    $finish;
  end

  initial
  begin : main
    cyc          <= 1'b0;
    stb          <= 1'b0;
    we           <= 1'b0;
    adr          <= '0;
    dat_w        <= '0;
    rst_n        <= 1'b0;
    lfsr_state   = 32'h218c;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    load_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tests[i])
      run_test(tests[i]);
    run_burst();
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, i_dut.i_wb_assert.violations);
    if (tests_failed == 0 && i_dut.i_wb_assert.violations == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: vlog.f
alu_pkg.sv
alu.sv
alu_fifo.sv
alu_cmd_front.sv
alu_exec.sv
alu_top.sv
alu_tb_assertions.sv
alu_tb.sv

// File: Makefile
SIM      = verilator
TOP      = alu_tb
FLIST    = vlog.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_ARGS = +verilator+error+limit+100
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
